//--- sim.f
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/mem_arbiter.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/memory_unit.sv
rtl/cpu_top.sv
tb/cpu_sva.sv
tb/cpu_tb.sv

//--- Makefile
SIM_DIR = obj_dir
SIM_BIN = cpu_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpu_tb \
		-Mdir $(SIM_DIR) -o $(SIM_BIN)

run: compile
	@out="$$(./$(SIM_DIR)/$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(SIM_DIR)

//--- tb/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam word_t DONE_ADDR = 32'h0000_03FC;
    localparam int    PROG_BASE = 0;
    localparam int    DATA_BASE = 32'h200;

    logic  clk;
    logic  reset;
    logic  mem_enable;
    logic  mem_write;
    word_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_ready;

    word_t mem [256];
    word_t iss_mem [256];
    word_t iss_addr [$];
    word_t iss_data [$];
    word_t st_addr [$];
    word_t st_data [$];

    int          seed;
    bit          random_mode;
    bit          done_seen;
    bit          aborted;
    int          store_idx;
    int          errors;
    int          checks;
    int          tests;
    string       cur_test;
    int unsigned emit_pc;

    cpu_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .mem_enable (mem_enable),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string what, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("ERR %s %s expected %h actual %h", cur_test, what, expected, actual);
        end
    endtask

    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic word_t enc_i(input int op, input int f3, input int rd, input int rs1,
                                    input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                    input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
    endfunction

    function automatic word_t enc_s(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(input int f3, input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_u(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], OP_LUI};
    endfunction

    function automatic word_t enc_j(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    task automatic emit(input word_t w);
        mem[emit_pc >> 2] = w;
        emit_pc += 4;
    endtask

    task automatic load_program(input int which);
        for (int i = 0; i < 256; i++)
        begin
            mem[i] = 32'hc0de_0000 ^ (i * 32'h0004_0004);
        end
        emit_pc = PROG_BASE;
        emit(enc_i(OP_IMM, 0, 31, 0, DATA_BASE));
        case (which)
            0:
            begin
                emit(enc_i(OP_IMM, 0, 1, 0, 100));
                emit(enc_i(OP_IMM, 0, 2, 0, -7));
                emit(enc_u(3, 20'h12345));
                emit(enc_i(OP_IMM, 3'b010, 4, 2, 5));
                emit(enc_i(OP_IMM, 3'b100, 5, 1, 12'h055));
                emit(enc_i(OP_IMM, 3'b110, 6, 2, 12'h030));
                emit(enc_i(OP_IMM, 3'b111, 7, 1, 12'h06c));
                emit(enc_r(0, 2, 1, 3'b000, 8));
                emit(enc_r(7'h20, 2, 1, 3'b000, 9));
                emit(enc_r(0, 1, 2, 3'b010, 10));
                emit(enc_r(0, 3, 1, 3'b100, 11));
                emit(enc_r(0, 3, 2, 3'b110, 12));
                emit(enc_r(0, 2, 1, 3'b111, 13));
                for (int r = 3; r <= 13; r++)
                begin
                    emit(enc_s(r, 31, (r - 3) * 4));
                end
            end
            1:
            begin
                // Distances one, two and three between producer and consumer
                emit(enc_i(OP_IMM, 0, 1, 0, 5));
                emit(enc_r(0, 1, 1, 3'b000, 2));
                emit(enc_i(OP_IMM, 0, 3, 0, 9));
                emit(enc_r(0, 3, 2, 3'b000, 4));
                emit(enc_i(OP_IMM, 0, 5, 0, 1));
                emit(enc_r(0, 4, 3, 3'b100, 6));
                emit(enc_r(0, 5, 6, 3'b000, 7));
                emit(enc_s(7, 31, 0));
                emit(enc_s(6, 31, 4));
                emit(enc_s(4, 31, 8));
                emit(enc_s(2, 31, 12));
            end
            2:
            begin
                emit(enc_i(OP_IMM, 0, 1, 0, 77));
                emit(enc_s(1, 31, 0));
                emit(enc_i(OP_LOAD, 3'b010, 2, 31, 0));
                emit(enc_r(0, 2, 2, 3'b000, 3));
                emit(enc_s(3, 31, 4));
                emit(enc_i(OP_LOAD, 3'b010, 4, 31, 64));
                emit(enc_s(4, 31, 8));
                emit(enc_i(OP_LOAD, 3'b010, 5, 31, 4));
                emit(enc_i(OP_IMM, 0, 6, 5, 1));
                emit(enc_s(6, 31, 12));
            end
            default:
            begin
                emit(enc_i(OP_IMM, 0, 1, 0, 3));
                emit(enc_i(OP_IMM, 0, 2, 0, 3));
                emit(enc_b(3'b000, 1, 2, 12));
                emit(enc_s(1, 31, 0));
                emit(enc_s(1, 31, 4));
                emit(enc_s(2, 31, 8));
                emit(enc_b(3'b001, 1, 2, 8));
                emit(enc_s(1, 31, 12));
                emit(enc_b(3'b001, 1, 0, 12));
                emit(enc_s(1, 31, 24));
                emit(enc_s(1, 31, 28));
                emit(enc_b(3'b000, 1, 0, 8));
                emit(enc_s(2, 31, 16));
                emit(enc_j(5, 12));
                emit(enc_s(1, 31, 32));
                emit(enc_s(1, 31, 36));
                emit(enc_s(5, 31, 20));
            end
        endcase
        // Done store, then spin in place
        emit(enc_s(0, 0, DONE_ADDR));
        emit(enc_j(0, 0));
    endtask

    // ------------------------------
    // Instruction-set reference model
    // ------------------------------
    function automatic void iss_run();
        word_t regs [32];
        word_t pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t res;
        word_t next;
        word_t addr;
        bit    wr;
        for (int i = 0; i < 32; i++)
        begin
            regs[i] = '0;
        end
        pc = '0;
        iss_addr.delete();
        iss_data.delete();
        for (int step = 0; step < 2000; step++)
        begin
            ins  = iss_mem[pc[9:2]];
            a    = regs[ins[19:15]];
            b    = regs[ins[24:20]];
            next = pc + 4;
            res  = '0;
            wr   = 1'b0;
            case (ins[6:0])
                OP_IMM, OP_REG:
                begin
                    if (ins[6:0] == OP_IMM)
                        b = {{20{ins[31]}}, ins[31:20]};
                    wr = 1'b1;
                    case (ins[14:12])
                        3'b010: res = ($signed(a) < $signed(b)) ? 1 : 0;
                        3'b100: res = a ^ b;
                        3'b110: res = a | b;
                        3'b111: res = a & b;
                        default: res = (ins[6:0] == OP_REG && ins[30]) ? a - b : a + b;
                    endcase
                end
                OP_LUI:
                begin
                    res = {ins[31:12], 12'h000};
                    wr  = 1'b1;
                end
                OP_LOAD:
                begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    res  = iss_mem[addr[9:2]];
                    wr   = 1'b1;
                end
                OP_STORE:
                begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    iss_mem[addr[9:2]] = b;
                    iss_addr.push_back(addr);
                    iss_data.push_back(b);
                    if (addr == DONE_ADDR)
                        return;
                end
                OP_BRANCH:
                begin
                    if ((ins[12] == 1'b0) ? (a == b) : (a != b))
                        next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                OP_JAL:
                begin
                    res  = pc + 4;
                    wr   = 1'b1;
                    next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default:
                begin
                    wr = 1'b0;
                end
            endcase
            if (wr && ins[11:7] != 0)
                regs[ins[11:7]] = res;
            pc = next;
        end
        errors++;
        $display("Reference model never reached the done store");
    endfunction

    // Memory model, responses change on the falling edge
    always @(negedge clk)
    begin
        logic rdy;
        rdy       = random_mode ? (($random(seed) & 3) != 0) : 1'b1;
        mem_ready = rdy;
        mem_rdata = mem[mem_addr[9:2]];
        if (mem_enable && mem_write && rdy)
        begin
            mem[mem_addr[9:2]] = mem_wdata;
            st_addr.push_back(mem_addr);
            st_data.push_back(mem_wdata);
        end
    end

    // Compares each completed store with the model's list
    always @(posedge clk)
    begin
        word_t a;
        word_t d;
        while (st_addr.size() > 0)
        begin
            a = st_addr.pop_front();
            d = st_data.pop_front();
            if (store_idx < iss_addr.size())
            begin
                check($sformatf("store %0d addr", store_idx), iss_addr[store_idx], a);
                check($sformatf("store %0d data", store_idx), iss_data[store_idx], d);
            end
            else
            begin
                errors++;
                $display("%s: unexpected store to %h after the expected list", cur_test, a);
            end
            if (a == DONE_ADDR)
                done_seen = 1'b1;
            store_idx++;
        end
    end

    task automatic apply_reset();
        int waited;
        reset = 1'b1;
        repeat (16)
        begin
            @(negedge clk);
            check("bus idle in reset", 32'd0, {30'd0, mem_enable, mem_write});
        end
        reset = 1'b0;
        waited = 0;
        while (!mem_enable && waited < 50)
        begin
            @(negedge clk);
            waited++;
        end
        if (!mem_enable)
        begin
            errors++;
            aborted = 1'b1;
            $display("Timeout: no bus request after reset in %s", cur_test);
        end
        else
        begin
            check("first request addr", 32'd0, mem_addr);
            check("first request write", 32'd0, {31'd0, mem_write});
        end
    endtask

    task automatic run_program(input int which, input string name, input bit stalls);
        int err0;
        int cycles;
        err0        = errors;
        cur_test    = name;
        random_mode = stalls;
        @(negedge clk);
        reset = 1'b1;
        load_program(which);
        iss_mem = mem;
        iss_run();
        st_addr.delete();
        st_data.delete();
        store_idx = 0;
        done_seen = 1'b0;
        apply_reset();
        if (!aborted)
        begin
            cycles = 0;
            while (!done_seen && cycles < 5000)
            begin
                @(negedge clk);
                cycles++;
            end
            if (!done_seen)
            begin
                errors++;
                aborted = 1'b1;
                $display("Timeout: %s never reached the done store", name);
            end
            else
            begin
                check("store count", iss_addr.size(), store_idx);
                tests++;
                $display("%s: %s", name, (errors == err0) ? "ok" : "FAIL");
            end
        end
    endtask

    initial
    begin
        string names [4];
        names       = '{"alu", "forwarding", "load_use", "branches"};
        seed        = 32'hd3d728ca;
        reset       = 1'b1;
        mem_ready   = 1'b0;
        mem_rdata   = '0;
        random_mode = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        store_idx   = 0;
        done_seen   = 1'b0;
        aborted     = 1'b0;

        cur_test = "reset";
        load_program(0);
        apply_reset();
        tests++;
        $display("reset: %s", (errors == 0) ? "ok" : "FAIL");

        for (int rm = 0; rm < 2; rm++)
        begin
            for (int p = 0; p < 4; p++)
            begin
                if (!aborted)
                begin
                    run_program(p, rm ? {names[p], "_stall"} : names[p], rm[0]);
                end
            end
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/cpu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_sva (
    input logic                clk,
    input logic                reset,
    input logic                mem_enable,
    input logic                mem_write,
    input cpu_pkg::word_t      mem_addr,
    input cpu_pkg::word_t      mem_wdata,
    input logic                mem_ready,
    input logic                data_req
);

    // Idle through reset and the first cycle after it
    a_reset_idle: assert property (@(posedge clk) reset |=> !mem_enable && !mem_write)
        else $error("bus active during reset");

    // Data accesses take priority, so the bus carries the waiting data request
    a_hold: assert property (@(posedge clk) disable iff (reset)
        data_req && !mem_ready |=> mem_enable && $stable(mem_addr) && $stable(mem_wdata))
        else $error("data request changed while waiting for ready");

    a_write_enable: assert property (@(posedge clk) disable iff (reset)
        mem_write |-> mem_enable)
        else $error("write without enable");

endmodule

bind cpu_top cpu_sva u_sva (
    .clk        (clk),
    .reset      (reset),
    .mem_enable (mem_enable),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ready  (mem_ready),
    .data_req   (data_bus.req)
);

`default_nettype wire

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic              clk,
    input  logic              reset,
    output logic              mem_enable,
    output logic              mem_write,
    output cpu_pkg::word_t    mem_addr,
    output cpu_pkg::word_t    mem_wdata,
    input  cpu_pkg::word_t    mem_rdata,
    input  logic              mem_ready
);
    import cpu_pkg::*;

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();

    // Fetch and decode
    word_t    d_insn;
    word_t    d_pc;
    logic     load_stall;
    logic     mem_stall;
    logic     flush;
    word_t    target;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    // Execute
    alu_op_e    x_op;
    opcode_t    x_opcode;
    logic [2:0] x_funct3;
    word_t      x_a;
    word_t      x_b;
    word_t      x_imm;
    word_t      x_pc;
    reg_idx_t   x_rd;
    logic       x_wen;
    word_t      ex_result;

    // Memory and writeback
    opcode_t  m_opcode;
    word_t    m_result;
    word_t    m_addr;
    word_t    m_store;
    reg_idx_t m_rd;
    logic     m_wen;
    word_t    mem_fwd;
    word_t    wb_data;
    reg_idx_t wb_idx;
    logic     wb_wen;

    mem_arbiter u_arbiter (
        .fetch_bus  (fetch_bus.arbiter),
        .data_bus   (data_bus.arbiter),
        .mem_enable (mem_enable),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    fetch_unit u_fetch (
        .clk    (clk),
        .reset  (reset),
        .bus    (fetch_bus.requester),
        .stall  (mem_stall || load_stall),
        .flush  (flush),
        .target (target),
        .insn   (d_insn),
        .pc     (d_pc)
    );

    decode_unit u_decode (
        .clk        (clk),
        .reset      (reset),
        .insn       (d_insn),
        .pc         (d_pc),
        .stall      (mem_stall),
        .flush      (flush),
        .load_stall (load_stall),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ex_idx     (x_rd),
        .mem_idx    (m_rd),
        .wb_idx     (wb_idx),
        .ex_wen     (x_wen),
        .mem_wen    (m_wen),
        .wb_wen     (wb_wen),
        .ex_is_load (x_opcode == OP_LOAD),
        .ex_fwd     (ex_result),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_data),
        .x_op       (x_op),
        .x_opcode   (x_opcode),
        .x_funct3   (x_funct3),
        .x_a        (x_a),
        .x_b        (x_b),
        .x_imm      (x_imm),
        .x_pc       (x_pc),
        .x_rd       (x_rd),
        .x_wen      (x_wen)
    );

    register_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_wen),
        .wr_idx   (wb_idx),
        .wr_data  (wb_data)
    );

    execute_unit u_execute (
        .clk       (clk),
        .reset     (reset),
        .stall     (mem_stall),
        .x_op      (x_op),
        .x_opcode  (x_opcode),
        .x_funct3  (x_funct3),
        .x_a       (x_a),
        .x_b       (x_b),
        .x_imm     (x_imm),
        .x_pc      (x_pc),
        .x_rd      (x_rd),
        .x_wen     (x_wen),
        .flush     (flush),
        .target    (target),
        .ex_result (ex_result),
        .m_opcode  (m_opcode),
        .m_result  (m_result),
        .m_addr    (m_addr),
        .m_store   (m_store),
        .m_rd      (m_rd),
        .m_wen     (m_wen)
    );

    memory_unit u_memory (
        .clk       (clk),
        .reset     (reset),
        .bus       (data_bus.requester),
        .m_opcode  (m_opcode),
        .m_result  (m_result),
        .m_addr    (m_addr),
        .m_store   (m_store),
        .m_rd      (m_rd),
        .m_wen     (m_wen),
        .mem_stall (mem_stall),
        .mem_fwd   (mem_fwd),
        .wb_data   (wb_data),
        .wb_idx    (wb_idx),
        .wb_wen    (wb_wen)
    );

endmodule

`default_nettype wire

//--- rtl/memory_unit.sv
`timescale 1ns/1ps
`default_nettype none

module memory_unit (
    input  logic                clk,
    input  logic                reset,
    mem_bus_if.requester        bus,
    input  cpu_pkg::opcode_t    m_opcode,
    input  cpu_pkg::word_t      m_result,
    input  cpu_pkg::word_t      m_addr,
    input  cpu_pkg::word_t      m_store,
    input  cpu_pkg::reg_idx_t   m_rd,
    input  logic                m_wen,
    output logic                mem_stall,
    output cpu_pkg::word_t      mem_fwd,
    output cpu_pkg::word_t      wb_data,
    output cpu_pkg::reg_idx_t   wb_idx,
    output logic                wb_wen
);
    import cpu_pkg::*;

    logic is_load;
    logic is_store;

    assign is_load  = (m_opcode == OP_LOAD);
    assign is_store = (m_opcode == OP_STORE);

    assign bus.req   = is_load || is_store;
    assign bus.we    = is_store;
    assign bus.addr  = m_addr;
    assign bus.wdata = m_store;

    // Whole pipeline waits on the data port
    assign mem_stall = bus.req && !bus.ready;

    // Load data is valid in the cycle ready is seen
    assign mem_fwd = is_load ? bus.rdata : m_result;

    // ------------------------------
    // Memory to writeback register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_idx <= '0;
            wb_wen <= 1'b0;
        end
        else
        begin
            wb_idx <= m_rd;
            // Bubble into writeback while waiting
            wb_wen <= m_wen && !mem_stall;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_data <= mem_fwd;
    end

endmodule

`default_nettype wire

//--- rtl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  cpu_pkg::alu_op_e    x_op,
    input  cpu_pkg::opcode_t    x_opcode,
    input  logic [2:0]          x_funct3,
    input  cpu_pkg::word_t      x_a,
    input  cpu_pkg::word_t      x_b,
    input  cpu_pkg::word_t      x_imm,
    input  cpu_pkg::word_t      x_pc,
    input  cpu_pkg::reg_idx_t   x_rd,
    input  logic                x_wen,
    output logic                flush,
    output cpu_pkg::word_t      target,
    output cpu_pkg::word_t      ex_result,
    output cpu_pkg::opcode_t    m_opcode,
    output cpu_pkg::word_t      m_result,
    output cpu_pkg::word_t      m_addr,
    output cpu_pkg::word_t      m_store,
    output cpu_pkg::reg_idx_t   m_rd,
    output logic                m_wen
);
    import cpu_pkg::*;

    word_t operand_b;
    word_t alu_y;
    logic  taken;

    // Register operand for R-type and branches, immediate otherwise
    assign operand_b = (x_opcode == OP_REG || x_opcode == OP_BRANCH) ? x_b : x_imm;

    always_comb
    begin
        case (x_op)
            ALU_SUB:    alu_y = x_a - operand_b;
            ALU_SLT:    alu_y = {{(XLEN-1){1'b0}}, $signed(x_a) < $signed(operand_b)};
            ALU_XOR:    alu_y = x_a ^ operand_b;
            ALU_OR:     alu_y = x_a | operand_b;
            ALU_AND:    alu_y = x_a & operand_b;
            ALU_PASS_B: alu_y = operand_b;
            default:    alu_y = x_a + operand_b;
        endcase
    end

    // ------------------------------
    // Branch and jump
    // ------------------------------
    // funct3 bit 0 selects BNE over BEQ
    assign taken  = x_funct3[0] ? (x_a != x_b) : (x_a == x_b);
    assign flush  = (x_opcode == OP_BRANCH && taken) || x_opcode == OP_JAL;
    assign target = x_pc + x_imm;

    assign ex_result = (x_opcode == OP_JAL) ? x_pc + 32'd4 : alu_y;

    // ------------------------------
    // Execute to memory register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            m_opcode <= OP_IMM;
            m_rd     <= '0;
            m_wen    <= 1'b0;
        end
        else if (!stall)
        begin
            m_opcode <= x_opcode;
            m_rd     <= x_rd;
            m_wen    <= x_wen;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            m_result <= ex_result;
            m_addr   <= alu_y;
            m_store  <= x_b;
        end
    end

endmodule

`default_nettype wire

//--- rtl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::word_t      insn,
    input  cpu_pkg::word_t      pc,
    input  logic                stall,
    input  logic                flush,
    output logic                load_stall,
    output cpu_pkg::reg_idx_t   rs1_idx,
    output cpu_pkg::reg_idx_t   rs2_idx,
    input  cpu_pkg::word_t      rs1_data,
    input  cpu_pkg::word_t      rs2_data,
    input  cpu_pkg::reg_idx_t   ex_idx,
    input  cpu_pkg::reg_idx_t   mem_idx,
    input  cpu_pkg::reg_idx_t   wb_idx,
    input  logic                ex_wen,
    input  logic                mem_wen,
    input  logic                wb_wen,
    input  logic                ex_is_load,
    input  cpu_pkg::word_t      ex_fwd,
    input  cpu_pkg::word_t      mem_fwd,
    input  cpu_pkg::word_t      wb_fwd,
    output cpu_pkg::alu_op_e    x_op,
    output cpu_pkg::opcode_t    x_opcode,
    output logic [2:0]          x_funct3,
    output cpu_pkg::word_t      x_a,
    output cpu_pkg::word_t      x_b,
    output cpu_pkg::word_t      x_imm,
    output cpu_pkg::word_t      x_pc,
    output cpu_pkg::reg_idx_t   x_rd,
    output logic                x_wen
);
    import cpu_pkg::*;

    opcode_t  opcode;
    logic [2:0] funct3;
    reg_idx_t rd;
    word_t    imm;
    alu_op_e  op;
    logic     writes;
    logic     uses_rs1;
    logic     uses_rs2;
    logic     bubble;

    // Youngest producer wins, x0 is never forwarded
    function automatic word_t forward(input reg_idx_t idx, input word_t rf);
        if (idx == '0)
            return rf;
        if (ex_wen && ex_idx == idx)
            return ex_fwd;
        if (mem_wen && mem_idx == idx)
            return mem_fwd;
        if (wb_wen && wb_idx == idx)
            return wb_fwd;
        return rf;
    endfunction

    // ------------------------------
    // Field extraction
    // ------------------------------
    assign opcode  = insn[6:0];
    assign rd      = insn[11:7];
    assign funct3  = insn[14:12];
    assign rs1_idx = insn[19:15];
    assign rs2_idx = insn[24:20];

    always_comb
    begin
        imm      = {{20{insn[31]}}, insn[31:20]};
        op       = ALU_ADD;
        writes   = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            OP_IMM, OP_REG:
            begin
                writes   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = (opcode == OP_REG);
                case (funct3)
                    3'b010:  op = ALU_SLT;
                    3'b100:  op = ALU_XOR;
                    3'b110:  op = ALU_OR;
                    3'b111:  op = ALU_AND;
                    default: op = (opcode == OP_REG && insn[30]) ? ALU_SUB : ALU_ADD;
                endcase
            end
            OP_LUI:
            begin
                imm    = {insn[31:12], 12'b0};
                op     = ALU_PASS_B;
                writes = 1'b1;
            end
            OP_LOAD:
            begin
                writes   = 1'b1;
                uses_rs1 = 1'b1;
            end
            OP_STORE:
            begin
                imm      = {{20{insn[31]}}, insn[31:25], insn[11:7]};
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP_BRANCH:
            begin
                imm      = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
                op       = ALU_SUB;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP_JAL:
            begin
                imm    = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
                writes = 1'b1;
            end
            default:
            begin
                op = ALU_ADD;
            end
        endcase
    end

    // Load result arrives too late for the next instruction
    assign load_stall = ex_is_load && ex_wen &&
                        ((uses_rs1 && ex_idx == rs1_idx) || (uses_rs2 && ex_idx == rs2_idx));
    assign bubble     = flush || load_stall;

    // ------------------------------
    // Decode to execute register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            x_op     <= ALU_ADD;
            x_opcode <= OP_IMM;
            x_funct3 <= 3'b000;
            x_rd     <= '0;
            x_wen    <= 1'b0;
        end
        else if (!stall)
        begin
            x_op     <= bubble ? ALU_ADD : op;
            x_opcode <= bubble ? OP_IMM : opcode;
            x_funct3 <= bubble ? 3'b000 : funct3;
            x_rd     <= bubble ? '0 : rd;
            x_wen    <= !bubble && writes && rd != '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            x_a   <= forward(rs1_idx, rs1_data);
            x_b   <= forward(rs2_idx, rs2_data);
            x_imm <= imm;
            x_pc  <= pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::reg_idx_t   rs1_idx,
    input  cpu_pkg::reg_idx_t   rs2_idx,
    output cpu_pkg::word_t      rs1_data,
    output cpu_pkg::word_t      rs2_data,
    input  logic                wr_en,
    input  cpu_pkg::reg_idx_t   wr_idx,
    input  cpu_pkg::word_t      wr_data
);
    import cpu_pkg::*;

    word_t regs [32];

    // x0 is never written, so it reads as zero
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && wr_idx != '0)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic              clk,
    input  logic              reset,
    mem_bus_if.requester      bus,
    input  logic              stall,
    input  logic              flush,
    input  cpu_pkg::word_t    target,
    output cpu_pkg::word_t    insn,
    output cpu_pkg::word_t    pc
);
    import cpu_pkg::*;

    word_t fetch_pc;
    // Keeps the bus idle in the first cycle after reset
    logic  active;

    assign bus.req   = active;
    assign bus.we    = 1'b0;
    assign bus.addr  = fetch_pc;
    assign bus.wdata = '0;

    // ------------------------------
    // Program counter and decode register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fetch_pc <= '0;
            active   <= 1'b0;
            insn     <= NOP_INSN;
        end
        else
        begin
            active <= 1'b1;
            if (!stall)
            begin
                if (flush)
                begin
                    // Outstanding fetch is dropped here
                    fetch_pc <= target;
                    insn     <= NOP_INSN;
                end
                else if (bus.ready)
                begin
                    fetch_pc <= fetch_pc + 32'd4;
                    insn     <= bus.rdata;
                end
                else
                begin
                    insn <= NOP_INSN;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall && !flush && bus.ready)
        begin
            pc <= fetch_pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    mem_bus_if.arbiter        fetch_bus,
    mem_bus_if.arbiter        data_bus,
    output logic              mem_enable,
    output logic              mem_write,
    output cpu_pkg::word_t    mem_addr,
    output cpu_pkg::word_t    mem_wdata,
    input  cpu_pkg::word_t    mem_rdata,
    input  logic              mem_ready
);
    import cpu_pkg::*;

    logic data_grant;
    logic fetch_grant;

    // Data port always wins, fetch waits
    assign data_grant  = data_bus.req;
    assign fetch_grant = fetch_bus.req && !data_bus.req;

    assign mem_enable = data_grant || fetch_grant;
    assign mem_write  = data_grant ? data_bus.we : (fetch_grant && fetch_bus.we);
    assign mem_addr   = data_grant ? data_bus.addr : fetch_bus.addr;
    assign mem_wdata  = data_grant ? data_bus.wdata : fetch_bus.wdata;

    // Only the granted port sees the response
    assign data_bus.ready  = data_grant && mem_ready;
    assign fetch_bus.ready = fetch_grant && mem_ready;
    assign data_bus.rdata  = data_grant ? mem_rdata : '0;
    assign fetch_bus.rdata = fetch_grant ? mem_rdata : '0;

endmodule

`default_nettype wire

//--- rtl/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    import cpu_pkg::*;

    logic  req;
    logic  we;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  ready;

    modport requester (output req, we, addr, wdata, input rdata, ready);
    modport arbiter (input req, we, addr, wdata, output rdata, ready);
endinterface

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [6:0]      opcode_t;

    // ------------------------------
    // Opcodes
    // ------------------------------
    localparam opcode_t OP_IMM    = 7'b001_0011;
    localparam opcode_t OP_REG    = 7'b011_0011;
    localparam opcode_t OP_LUI    = 7'b011_0111;
    localparam opcode_t OP_LOAD   = 7'b000_0011;
    localparam opcode_t OP_STORE  = 7'b010_0011;
    localparam opcode_t OP_BRANCH = 7'b110_0011;
    localparam opcode_t OP_JAL    = 7'b110_1111;

    // ALU operations, pass-b serves LUI
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // ADDI x0,x0,0
    localparam word_t NOP_INSN = 32'h0000_0013;

endpackage

`default_nettype wire
